//--- hw/rvseed_pkg.sv
// shared package: data widths and types, memory depth, reset pc, opcode/alu/writeback enums, alu function
package rvseed_pkg;

    localparam int XLEN       = 64;
    localparam int DMEM_WORDS = 64;                     // doublewords
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;

    localparam xlen_t RESET_PC    = '0;
    localparam inst_t EBREAK_INST = 32'h0010_0073;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B                                      // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK                                         // pc + 4
    } wb_sel_e;

    // execute uses it, and decode uses it to forward the instruction in execute
    function automatic xlen_t alu_calc(alu_op_e op, xlen_t a, xlen_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: return b;
        endcase
    endfunction

endpackage

//--- hw/rvseed_pipe_if.sv
// stage payload interfaces: id_ex_if, ex_mem_if and mem_wb_if with producer and consumer modports
interface id_ex_if;
    import rvseed_pkg::*;

    logic      valid;
    xlen_t     pc;
    alu_op_e   alu_op;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     store_data;
    reg_addr_t rd;
    logic      reg_wen;
    logic      mem_rd;
    logic      mem_wr;
    wb_sel_e   wb_sel;
    logic      branch;
    logic      jump;
    logic      branch_ne;                               // bne when set, beq otherwise
    xlen_t     branch_offset;
    logic      ebreak;

    modport producer (output valid, pc, alu_op, operand_a, operand_b, store_data, rd, reg_wen,
                      mem_rd, mem_wr, wb_sel, branch, jump, branch_ne, branch_offset, ebreak);
    modport consumer (input valid, pc, alu_op, operand_a, operand_b, store_data, rd, reg_wen,
                      mem_rd, mem_wr, wb_sel, branch, jump, branch_ne, branch_offset, ebreak);
endinterface

interface ex_mem_if;
    import rvseed_pkg::*;

    logic      valid;
    xlen_t     pc;
    xlen_t     alu_result;                              // also address and link value
    xlen_t     store_data;
    reg_addr_t rd;
    logic      reg_wen;
    logic      mem_rd;
    logic      mem_wr;
    wb_sel_e   wb_sel;
    logic      ebreak;

    modport producer (output valid, pc, alu_result, store_data, rd, reg_wen, mem_rd, mem_wr,
                      wb_sel, ebreak);
    modport consumer (input valid, pc, alu_result, store_data, rd, reg_wen, mem_rd, mem_wr,
                      wb_sel, ebreak);
endinterface

interface mem_wb_if;
    import rvseed_pkg::*;

    logic      valid;
    xlen_t     pc;
    xlen_t     result;
    reg_addr_t rd;
    logic      reg_wen;
    logic      ebreak;

    modport producer (output valid, pc, result, rd, reg_wen, ebreak);
    modport consumer (input valid, pc, result, rd, reg_wen, ebreak);
endinterface

//--- hw/rvseed_fetch.sv
// fetch stage: program counter with stall, redirect and halt handling, IF/ID register
module rvseed_fetch (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              stall_i,
    input  logic              redirect_i,
    input  rvseed_pkg::xlen_t redirect_pc_i,
    input  logic              halted_i,
    output rvseed_pkg::xlen_t imem_addr_o,
    input  rvseed_pkg::inst_t imem_data_i,
    output logic              id_valid_o,
    output rvseed_pkg::xlen_t id_pc_o,
    output rvseed_pkg::inst_t id_inst_o
);
    import rvseed_pkg::*;

    xlen_t pc_q;
    logic  advance;

    assign imem_addr_o = pc_q;                          // imem answers in the same cycle
    assign advance     = !stall_i && !halted_i && !redirect_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q       <= RESET_PC;
            id_valid_o <= 1'b0;
        end else if (halted_i) begin
            id_valid_o <= 1'b0;                         // frozen after ebreak
        end else if (redirect_i) begin
            pc_q       <= redirect_pc_i;
            id_valid_o <= 1'b0;                         // drop the wrong-path word
        end else if (!stall_i) begin
            pc_q       <= pc_q + xlen_t'(4);
            id_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            id_pc_o   <= pc_q;
            id_inst_o <= imem_data_i;
        end
    end

    // a load sits in execute during a stall, so no branch can redirect then
    assert property (@(posedge clk) disable iff (reset_i) !(stall_i && redirect_i))
        else $error("stall and redirect in the same cycle");

endmodule

//--- hw/rvseed_decode.sv
// decode stage with decoder, register file, operand forwarding, load-use stall and ID/EX register
module rvseed_decode (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  id_valid_i,
    input  rvseed_pkg::xlen_t     id_pc_i,
    input  rvseed_pkg::inst_t     id_inst_i,
    input  logic                  redirect_i,
    input  rvseed_pkg::reg_addr_t fwd_rd_i,
    input  logic                  fwd_wen_i,
    input  rvseed_pkg::xlen_t     fwd_data_i,
    input  logic                  wb_wen_i,
    input  rvseed_pkg::reg_addr_t wb_rd_i,
    input  rvseed_pkg::xlen_t     wb_data_i,
    output logic                  stall_o,
    id_ex_if.producer             ex_o
);
    import rvseed_pkg::*;

    opcode_e    opcode;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm;
    logic       legal;
    logic       use_rs1;
    logic       use_rs2;
    logic       sel_imm;
    logic       reg_wen;
    logic       mem_rd;
    logic       mem_wr;
    logic       branch;
    logic       jump;
    logic       ebreak;
    alu_op_e    alu_op;
    wb_sel_e    wb_sel;
    xlen_t      regs [32];
    logic       ex_fwd_en;
    reg_addr_t  ex_fwd_rd;
    xlen_t      ex_result;
    xlen_t      rs1_val;
    xlen_t      rs2_val;

    assign opcode = opcode_e'(id_inst_i[6:0]);
    assign rs1    = id_inst_i[19:15];
    assign rs2    = id_inst_i[24:20];
    assign funct3 = id_inst_i[14:12];
    assign funct7 = id_inst_i[31:25];

    always_comb begin
        legal   = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        sel_imm = 1'b1;
        reg_wen = 1'b0;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        branch  = 1'b0;
        jump    = 1'b0;
        ebreak  = 1'b0;
        alu_op  = ALU_ADD;
        wb_sel  = WB_ALU;
        imm     = {{52{id_inst_i[31]}}, id_inst_i[31:20]};   // i-type
        case (opcode)
            OPC_OP: begin
                use_rs2 = 1'b1;
                sel_imm = 1'b0;
                reg_wen = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b111:  alu_op = ALU_AND;
                    3'b110:  alu_op = ALU_OR;
                    3'b100:  alu_op = ALU_XOR;
                    3'b010:  alu_op = ALU_SLT;
                    default: legal  = 1'b0;
                endcase
                if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    legal = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                reg_wen = 1'b1;
                legal   = (funct3 == 3'b000);                 // addi only
            end
            OPC_LUI: begin
                use_rs1 = 1'b0;
                reg_wen = 1'b1;
                alu_op  = ALU_PASS_B;
                imm     = {{32{id_inst_i[31]}}, id_inst_i[31:12], 12'b0};
            end
            OPC_LOAD: begin
                reg_wen = 1'b1;
                mem_rd  = 1'b1;
                wb_sel  = WB_MEM;
                legal   = (funct3 == 3'b011);                 // ld
            end
            OPC_STORE: begin
                use_rs2 = 1'b1;
                mem_wr  = 1'b1;
                imm     = {{52{id_inst_i[31]}}, id_inst_i[31:25], id_inst_i[11:7]};
                legal   = (funct3 == 3'b011);                 // sd
            end
            OPC_BRANCH: begin
                use_rs2 = 1'b1;
                sel_imm = 1'b0;
                branch  = 1'b1;
                imm     = {{51{id_inst_i[31]}}, id_inst_i[31], id_inst_i[7],
                           id_inst_i[30:25], id_inst_i[11:8], 1'b0};
                legal   = (funct3 == 3'b000) || (funct3 == 3'b001);
            end
            OPC_JAL: begin
                use_rs1 = 1'b0;
                reg_wen = 1'b1;
                jump    = 1'b1;
                wb_sel  = WB_LINK;
                imm     = {{43{id_inst_i[31]}}, id_inst_i[31], id_inst_i[19:12],
                           id_inst_i[20], id_inst_i[30:21], 1'b0};
            end
            OPC_SYSTEM: begin
                use_rs1 = 1'b0;
                ebreak  = 1'b1;
                legal   = (id_inst_i == EBREAK_INST);
            end
            default: legal = 1'b0;
        endcase
    end

    // result of the instruction in execute rebuilt from our ID/EX payload
    assign ex_fwd_en = ex_o.valid && ex_o.reg_wen;
    assign ex_fwd_rd = ex_o.rd;
    assign ex_result = (ex_o.wb_sel == WB_LINK) ? ex_o.pc + xlen_t'(4)
                                                : alu_calc(ex_o.alu_op, ex_o.operand_a,
                                                           ex_o.operand_b);

    // nearest producer wins
    function automatic xlen_t read_operand(reg_addr_t rs);
        xlen_t value;
        if (rs == '0) begin
            value = '0;
        end else if (ex_fwd_en && ex_fwd_rd == rs) begin
            value = ex_result;
        end else if (fwd_wen_i && fwd_rd_i == rs) begin
            value = fwd_data_i;
        end else if (wb_wen_i && wb_rd_i == rs) begin
            value = wb_data_i;                                 // write port bypass
        end else begin
            value = regs[rs];
        end
        return value;
    endfunction

    always_comb begin
        rs1_val = read_operand(rs1);
        rs2_val = read_operand(rs2);
    end

    always_ff @(posedge clk) begin
        if (wb_wen_i) begin
            regs[wb_rd_i] <= wb_data_i;                        // x0 already filtered
        end
    end

    // load data is not ready until the load reaches memory
    assign stall_o = id_valid_i && ex_o.valid && ex_o.mem_rd && ex_o.rd != '0 &&
                     ((use_rs1 && rs1 == ex_o.rd) || (use_rs2 && rs2 == ex_o.rd));

    always_ff @(posedge clk) begin
        if (reset_i || redirect_i) begin
            ex_o.valid <= 1'b0;
        end else begin
            ex_o.valid <= id_valid_i && !stall_o;              // bubble while stalled
        end
    end

    always_ff @(posedge clk) begin
        ex_o.pc            <= id_pc_i;
        ex_o.alu_op        <= alu_op;
        ex_o.operand_a     <= rs1_val;
        ex_o.operand_b     <= sel_imm ? imm : rs2_val;
        ex_o.store_data    <= rs2_val;
        ex_o.rd            <= id_inst_i[11:7];
        ex_o.reg_wen       <= reg_wen;
        ex_o.mem_rd        <= mem_rd;
        ex_o.mem_wr        <= mem_wr;
        ex_o.wb_sel        <= wb_sel;
        ex_o.branch        <= branch;
        ex_o.jump          <= jump;
        ex_o.branch_ne     <= funct3[0];
        ex_o.branch_offset <= imm;
        ex_o.ebreak        <= ebreak;
    end

    // the stalled instruction waits in IF/ID for the next cycle
    assert property (@(posedge clk) disable iff (reset_i)
        stall_o |=> $stable(id_inst_i) && $stable(id_pc_i))
        else $error("IF/ID changed during a load-use stall");

    assert property (@(posedge clk) disable iff (reset_i) id_valid_i |-> legal)
        else $error("unsupported instruction %h at pc %h", id_inst_i, id_pc_i);

endmodule

//--- hw/rvseed_execute.sv
// execute stage with alu, branch compare, redirect and EX/MEM register
module rvseed_execute (
    input  logic              clk,
    input  logic              reset_i,
    id_ex_if.consumer         ex_i,
    ex_mem_if.producer        mem_o,
    output logic              redirect_o,
    output rvseed_pkg::xlen_t redirect_pc_o
);
    import rvseed_pkg::*;

    xlen_t alu_result;
    logic  operands_eq;
    logic  taken;

    assign alu_result  = alu_calc(ex_i.alu_op, ex_i.operand_a, ex_i.operand_b);
    assign operands_eq = (ex_i.operand_a == ex_i.operand_b);
    assign taken       = ex_i.jump || (ex_i.branch && (operands_eq != ex_i.branch_ne));

    assign redirect_o    = ex_i.valid && taken;
    assign redirect_pc_o = ex_i.pc + ex_i.branch_offset;    // branch and jal targets

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_o.valid <= 1'b0;
        end else begin
            mem_o.valid <= ex_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_o.pc         <= ex_i.pc;
        mem_o.alu_result <= (ex_i.wb_sel == WB_LINK) ? ex_i.pc + xlen_t'(4) : alu_result;
        mem_o.store_data <= ex_i.store_data;
        mem_o.rd         <= ex_i.rd;
        mem_o.reg_wen    <= ex_i.reg_wen;
        mem_o.mem_rd     <= ex_i.mem_rd;
        mem_o.mem_wr     <= ex_i.mem_wr;
        mem_o.wb_sel     <= ex_i.wb_sel;
        mem_o.ebreak     <= ex_i.ebreak;
    end

    // the instruction behind a taken branch or jump is flushed from ID/EX
    assert property (@(posedge clk) disable iff (reset_i) redirect_o |=> !ex_i.valid)
        else $error("redirect without flush of the younger instruction");

endmodule

//--- hw/rvseed_memory.sv
// memory stage: doubleword data memory, load and store, forward path, MEM/WB register
module rvseed_memory (
    input  logic                  clk,
    input  logic                  reset_i,
    ex_mem_if.consumer            mem_i,
    mem_wb_if.producer            wb_o,
    output rvseed_pkg::reg_addr_t fwd_rd_o,
    output logic                  fwd_wen_o,
    output rvseed_pkg::xlen_t     fwd_data_o
);
    import rvseed_pkg::*;

    xlen_t                 dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] word_idx;
    xlen_t                 result;

    assign word_idx = mem_i.alu_result[DMEM_IDX_W+2:3];     // drop byte offset

    always_ff @(posedge clk) begin
        if (mem_i.valid && mem_i.mem_wr) begin
            dmem[word_idx] <= mem_i.store_data;
        end
    end

    assign result = (mem_i.wb_sel == WB_MEM) ? dmem[word_idx] : mem_i.alu_result;

    // load data goes back to decode in the same cycle
    assign fwd_wen_o  = mem_i.valid && mem_i.reg_wen;
    assign fwd_rd_o   = mem_i.rd;
    assign fwd_data_o = result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= mem_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_o.pc      <= mem_i.pc;
        wb_o.result  <= result;
        wb_o.rd      <= mem_i.rd;
        wb_o.reg_wen <= mem_i.reg_wen;
        wb_o.ebreak  <= mem_i.ebreak;
    end

    // the address comes from the execute adder
    assert property (@(posedge clk) disable iff (reset_i)
        mem_i.valid && (mem_i.mem_rd || mem_i.mem_wr) |->
            mem_i.alu_result[2:0] == 3'b0 && mem_i.alu_result < xlen_t'(DMEM_WORDS * 8))
        else $error("bad data address %h at pc %h", mem_i.alu_result, mem_i.pc);

endmodule

//--- hw/rvseed_writeback.sv
// writeback stage: register write port, commit port select, halt latch
module rvseed_writeback (
    input  logic                  clk,
    input  logic                  reset_i,
    mem_wb_if.consumer            wb_i,
    output logic                  rf_wen_o,
    output rvseed_pkg::reg_addr_t rf_rd_o,
    output rvseed_pkg::xlen_t     rf_data_o,
    output logic                  commit_valid_o,
    output rvseed_pkg::xlen_t     commit_pc_o,
    output rvseed_pkg::reg_addr_t commit_rd_o,
    output rvseed_pkg::xlen_t     commit_data_o,
    output logic                  halted_o
);
    import rvseed_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            halted_o <= 1'b0;
        end else if (wb_i.valid && wb_i.ebreak) begin
            halted_o <= 1'b1;                               // sticky until reset
        end
    end

    assign commit_valid_o = wb_i.valid && !wb_i.ebreak && !halted_o;
    assign rf_wen_o       = commit_valid_o && wb_i.reg_wen && wb_i.rd != '0;
    assign rf_rd_o        = wb_i.rd;
    assign rf_data_o      = wb_i.result;

    // no register write shows as rd zero with zero data
    assign commit_pc_o   = wb_i.pc;
    assign commit_rd_o   = rf_wen_o ? wb_i.rd : '0;
    assign commit_data_o = rf_wen_o ? wb_i.result : '0;

endmodule

//--- hw/rvseed_top.sv
// core top level: payload interfaces and the five pipeline stages
module rvseed_top (
    input  logic                  clk,
    input  logic                  reset_i,
    output rvseed_pkg::xlen_t     imem_addr_o,
    input  rvseed_pkg::inst_t     imem_data_i,
    output logic                  commit_valid_o,
    output rvseed_pkg::xlen_t     commit_pc_o,
    output rvseed_pkg::reg_addr_t commit_rd_o,
    output rvseed_pkg::xlen_t     commit_data_o,
    output logic                  halted_o
);
    import rvseed_pkg::*;

    logic      stall;
    logic      redirect;
    xlen_t     redirect_pc;
    logic      id_valid;
    xlen_t     id_pc;
    inst_t     id_inst;
    reg_addr_t fwd_rd;
    logic      fwd_wen;
    xlen_t     fwd_data;
    logic      rf_wen;
    reg_addr_t rf_rd;
    xlen_t     rf_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    rvseed_fetch u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .halted_i      (halted_o),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .id_valid_o    (id_valid),
        .id_pc_o       (id_pc),
        .id_inst_o     (id_inst)
    );

    rvseed_decode u_decode (
        .clk        (clk),
        .reset_i    (reset_i),
        .id_valid_i (id_valid),
        .id_pc_i    (id_pc),
        .id_inst_i  (id_inst),
        .redirect_i (redirect),
        .fwd_rd_i   (fwd_rd),
        .fwd_wen_i  (fwd_wen),
        .fwd_data_i (fwd_data),
        .wb_wen_i   (rf_wen),
        .wb_rd_i    (rf_rd),
        .wb_data_i  (rf_data),
        .stall_o    (stall),
        .ex_o       (id_ex.producer)
    );

    rvseed_execute u_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .ex_i          (id_ex.consumer),
        .mem_o         (ex_mem.producer),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    rvseed_memory u_memory (
        .clk        (clk),
        .reset_i    (reset_i),
        .mem_i      (ex_mem.consumer),
        .wb_o       (mem_wb.producer),
        .fwd_rd_o   (fwd_rd),
        .fwd_wen_o  (fwd_wen),
        .fwd_data_o (fwd_data)
    );

    rvseed_writeback u_writeback (
        .clk            (clk),
        .reset_i        (reset_i),
        .wb_i           (mem_wb.consumer),
        .rf_wen_o       (rf_wen),
        .rf_rd_o        (rf_rd),
        .rf_data_o      (rf_data),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .halted_o       (halted_o)
    );

endmodule

//--- verification/rvseed_programs.svh
// program table: instruction words and expected commit records (pc, rd, data) per program
`ifndef RVSEED_PROGRAMS_SVH
`define RVSEED_PROGRAMS_SVH

task automatic fill_programs();
    // alu chain, every operand comes from one or two instructions back
    prog_name[0] = "alu_chain";
    add_inst(0, i_type(OPC_OP_IMM, 5'd1, 5'd0, 3'b000, 5));
    add_inst(0, i_type(OPC_OP_IMM, 5'd2, 5'd0, 3'b000, -3));
    add_inst(0, r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));     // add
    add_inst(0, r_type(7'b0100000, 5'd1, 5'd2, 3'b000, 5'd4));     // sub
    add_inst(0, r_type(7'b0000000, 5'd2, 5'd4, 3'b111, 5'd5));     // and
    add_inst(0, r_type(7'b0000000, 5'd4, 5'd1, 3'b110, 5'd6));     // or
    add_inst(0, r_type(7'b0000000, 5'd1, 5'd6, 3'b100, 5'd7));     // xor
    add_inst(0, r_type(7'b0000000, 5'd1, 5'd4, 3'b010, 5'd8));     // slt -8 < 5
    add_inst(0, r_type(7'b0000000, 5'd4, 5'd1, 3'b010, 5'd9));     // slt 5 < -8
    add_inst(0, EBREAK_INST);
    add_commit(0, 64'd0, 5'd1, 64'd5);
    add_commit(0, 64'd4, 5'd2, 64'hFFFF_FFFF_FFFF_FFFD);
    add_commit(0, 64'd8, 5'd3, 64'd2);
    add_commit(0, 64'd12, 5'd4, 64'hFFFF_FFFF_FFFF_FFF8);
    add_commit(0, 64'd16, 5'd5, 64'hFFFF_FFFF_FFFF_FFF8);
    add_commit(0, 64'd20, 5'd6, 64'hFFFF_FFFF_FFFF_FFFD);
    add_commit(0, 64'd24, 5'd7, 64'hFFFF_FFFF_FFFF_FFF8);
    add_commit(0, 64'd28, 5'd8, 64'd1);
    add_commit(0, 64'd32, 5'd9, 64'd0);

    // store, then loads used right away
    prog_name[1] = "load_use";
    add_inst(1, i_type(OPC_OP_IMM, 5'd1, 5'd0, 3'b000, 64));
    add_inst(1, i_type(OPC_OP_IMM, 5'd2, 5'd0, 3'b000, -77));
    add_inst(1, s_type(5'd2, 5'd1, 8));                             // sd x2, 8(x1)
    add_inst(1, i_type(OPC_LOAD, 5'd3, 5'd1, 3'b011, 8));
    add_inst(1, r_type(7'b0000000, 5'd1, 5'd3, 3'b000, 5'd4));     // uses load at once
    add_inst(1, i_type(OPC_LOAD, 5'd5, 5'd1, 3'b011, 8));
    add_inst(1, r_type(7'b0100000, 5'd5, 5'd1, 3'b000, 5'd6));
    add_inst(1, EBREAK_INST);
    add_commit(1, 64'd0, 5'd1, 64'd64);
    add_commit(1, 64'd4, 5'd2, 64'hFFFF_FFFF_FFFF_FFB3);
    add_commit(1, 64'd8, 5'd0, 64'd0);                              // store writes no register
    add_commit(1, 64'd12, 5'd3, 64'hFFFF_FFFF_FFFF_FFB3);
    add_commit(1, 64'd16, 5'd4, 64'hFFFF_FFFF_FFFF_FFF3);
    add_commit(1, 64'd20, 5'd5, 64'hFFFF_FFFF_FFFF_FFB3);
    add_commit(1, 64'd24, 5'd6, 64'd141);

    prog_name[2] = "branches";
    add_inst(2, i_type(OPC_OP_IMM, 5'd1, 5'd0, 3'b000, 7));
    add_inst(2, i_type(OPC_OP_IMM, 5'd2, 5'd0, 3'b000, 7));
    add_inst(2, b_type(3'b000, 5'd2, 5'd1, 12));                    // beq taken to 20
    add_inst(2, i_type(OPC_OP_IMM, 5'd3, 5'd0, 3'b000, 1));
    add_inst(2, i_type(OPC_OP_IMM, 5'd3, 5'd0, 3'b000, 2));
    add_inst(2, b_type(3'b001, 5'd2, 5'd1, 8));                     // bne falls through
    add_inst(2, i_type(OPC_OP_IMM, 5'd4, 5'd0, 3'b000, 9));
    add_inst(2, b_type(3'b001, 5'd4, 5'd1, 12));                    // bne taken to 40
    add_inst(2, i_type(OPC_OP_IMM, 5'd5, 5'd0, 3'b000, 1));
    add_inst(2, i_type(OPC_OP_IMM, 5'd5, 5'd0, 3'b000, 2));
    add_inst(2, i_type(OPC_OP_IMM, 5'd6, 5'd4, 3'b000, 1));
    add_inst(2, EBREAK_INST);
    add_commit(2, 64'd0, 5'd1, 64'd7);
    add_commit(2, 64'd4, 5'd2, 64'd7);
    add_commit(2, 64'd8, 5'd0, 64'd0);
    add_commit(2, 64'd20, 5'd0, 64'd0);
    add_commit(2, 64'd24, 5'd4, 64'd9);
    add_commit(2, 64'd28, 5'd0, 64'd0);
    add_commit(2, 64'd40, 5'd6, 64'd10);

    prog_name[3] = "jal_x0";
    add_inst(3, j_type(5'd1, 12));                                  // jal x1 to 12
    add_inst(3, i_type(OPC_OP_IMM, 5'd2, 5'd0, 3'b000, 1));
    add_inst(3, i_type(OPC_OP_IMM, 5'd2, 5'd0, 3'b000, 2));
    add_inst(3, i_type(OPC_OP_IMM, 5'd0, 5'd0, 3'b000, 55));       // write to x0
    add_inst(3, r_type(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd3));
    add_inst(3, r_type(7'b0000000, 5'd0, 5'd1, 3'b000, 5'd4));
    add_inst(3, j_type(5'd0, 8));                                   // jal x0 to 32
    add_inst(3, i_type(OPC_OP_IMM, 5'd5, 5'd0, 3'b000, 1));
    add_inst(3, EBREAK_INST);
    add_commit(3, 64'd0, 5'd1, 64'd4);
    add_commit(3, 64'd12, 5'd0, 64'd0);
    add_commit(3, 64'd16, 5'd3, 64'd0);
    add_commit(3, 64'd20, 5'd4, 64'd4);
    add_commit(3, 64'd24, 5'd0, 64'd0);

    prog_name[4] = "lui_halt";
    add_inst(4, u_type(5'd1, 20'h12345));
    add_inst(4, u_type(5'd2, 20'h80000));
    add_inst(4, i_type(OPC_OP_IMM, 5'd3, 5'd1, 3'b000, 12'h678));
    add_inst(4, EBREAK_INST);
    add_inst(4, i_type(OPC_OP_IMM, 5'd4, 5'd0, 3'b000, 1));        // never commits
    add_inst(4, i_type(OPC_OP_IMM, 5'd5, 5'd0, 3'b000, 2));
    add_commit(4, 64'd0, 5'd1, 64'h0000_0000_1234_5000);
    add_commit(4, 64'd4, 5'd2, 64'hFFFF_FFFF_8000_0000);
    add_commit(4, 64'd8, 5'd3, 64'h0000_0000_1234_5678);
endtask

`endif

//--- verification/rvseed_tb.sv
// testbench: clock, reset, instruction memory model, commit checks, timeout and summary
module rvseed_tb;
    import rvseed_pkg::*;

    localparam int    NUM_PROGS = 5;
    localparam int    MAX_WORDS = 16;
    localparam inst_t NOP       = 32'h0000_0013;

    logic      clk;
    logic      reset_i;
    xlen_t     imem_addr;
    inst_t     imem_data;
    logic      commit_valid;
    xlen_t     commit_pc;
    reg_addr_t commit_rd;
    xlen_t     commit_data;
    logic      halted;

    string     prog_name [NUM_PROGS];
    inst_t     prog_code [NUM_PROGS][MAX_WORDS];
    int        prog_len  [NUM_PROGS];
    xlen_t     exp_pc    [NUM_PROGS][MAX_WORDS];
    reg_addr_t exp_rd    [NUM_PROGS][MAX_WORDS];
    xlen_t     exp_data  [NUM_PROGS][MAX_WORDS];
    int        exp_count [NUM_PROGS];

    inst_t     imem [64];
    int        imem_len;
    int        error_count;
    int        tests_passed;
    int        tests_failed;
    int        cycle_count;
    int        cycle_limit;

    rvseed_top rvseed_top_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .commit_valid_o (commit_valid),
        .commit_pc_o    (commit_pc),
        .commit_rd_o    (commit_rd),
        .commit_data_o  (commit_data),
        .halted_o       (halted)
    );

    // nop past the end of the program
    assign imem_data = ((imem_addr >> 2) < xlen_t'(imem_len)) ? imem[imem_addr[7:2]] : NOP;

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the core never halted", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    function automatic inst_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t i_type(opcode_e opc, reg_addr_t rd, reg_addr_t rs1,
                                     logic [2:0] f3, int imm);
        logic [11:0] i;
        i = imm[11:0];
        return {i, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t s_type(reg_addr_t rs2, reg_addr_t rs1, int imm);
        logic [11:0] s;
        s = imm[11:0];
        return {s[11:5], rs2, rs1, 3'b011, s[4:0], OPC_STORE};   // sd
    endfunction

    function automatic inst_t b_type(logic [2:0] f3, reg_addr_t rs2, reg_addr_t rs1, int imm);
        logic [12:0] b;
        b = imm[12:0];
        return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], OPC_BRANCH};
    endfunction

    function automatic inst_t u_type(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic inst_t j_type(reg_addr_t rd, int imm);
        logic [20:0] j;
        j = imm[20:0];
        return {j[20], j[10:1], j[11], j[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_inst(int p, inst_t word);
        prog_code[p][prog_len[p]] = word;
        prog_len[p] = prog_len[p] + 1;
    endtask

    task automatic add_commit(int p, xlen_t pc, reg_addr_t rd, xlen_t data);
        exp_pc[p][exp_count[p]]   = pc;
        exp_rd[p][exp_count[p]]   = rd;
        exp_data[p][exp_count[p]] = data;
        exp_count[p] = exp_count[p] + 1;
    endtask

    `include "rvseed_programs.svh"

    task automatic compare_xlen(string test, string field, xlen_t expected, xlen_t actual);
        if (expected !== actual) begin
            $display("FAILED %s %s expected %h actual %h", test, field, expected, actual);
            error_count = error_count + 1;
        end
    endtask

    task automatic compare_reg(string test, string field, reg_addr_t expected,
                               reg_addr_t actual);
        if (expected !== actual) begin
            $display("FAILED %s %s expected x%0d actual x%0d", test, field, expected, actual);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_commit(int p, int idx);
        compare_xlen(prog_name[p], $sformatf("commit %0d pc", idx), exp_pc[p][idx], commit_pc);
        compare_reg(prog_name[p], $sformatf("commit %0d rd", idx), exp_rd[p][idx], commit_rd);
        compare_xlen(prog_name[p], $sformatf("commit %0d data", idx), exp_data[p][idx],
                     commit_data);
    endtask

    task automatic check_halt(int p, int commits);
        if (halted !== 1'b1) begin
            $display("%s: halted_o is not high after ebreak", prog_name[p]);
            error_count = error_count + 1;
        end
        if (commits != exp_count[p]) begin
            $display("FAILED %s commit count expected %0d actual %0d", prog_name[p],
                     exp_count[p], commits);
            error_count = error_count + 1;
        end
    endtask

    task automatic run_program(int p);
        int commits;
        int errors_before;
        commits       = 0;
        errors_before = error_count;
        for (int i = 0; i < prog_len[p]; i++) begin
            imem[i] = prog_code[p][i];
        end
        imem_len = prog_len[p];
        @(posedge clk);
        #1 reset_i = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset_i = 1'b0;
        while (!halted) begin
            @(negedge clk);                                 // outputs settled mid cycle
            if (commit_valid) begin
                if (commits < exp_count[p]) begin
                    check_commit(p, commits);
                end else begin
                    $display("%s: unexpected extra commit at pc %h", prog_name[p], commit_pc);
                    error_count = error_count + 1;
                end
                commits = commits + 1;
            end
        end
        repeat (8) begin
            @(negedge clk);
            if (commit_valid) begin
                $display("%s: commit at pc %h after halt", prog_name[p], commit_pc);
                error_count = error_count + 1;
            end
        end
        check_halt(p, commits);
        if (error_count == errors_before) begin
            tests_passed = tests_passed + 1;
            $display("PASS %s: %0d commits", prog_name[p], commits);
        end else begin
            tests_failed = tests_failed + 1;
            $display("FAIL %s: %0d errors", prog_name[p], error_count - errors_before);
        end
    endtask

    initial begin
        int total_words;
        clk          = 1'b0;
        reset_i      = 1'b1;
        imem_len     = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        total_words  = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            prog_len[p]  = 0;
            exp_count[p] = 0;
        end
        fill_programs();
        for (int p = 0; p < NUM_PROGS; p++) begin
            total_words = total_words + prog_len[p];
        end
        cycle_limit = 20 * total_words + 40 * NUM_PROGS;
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("programs %0d, passed %0d, failed %0d, errors %0d", NUM_PROGS,
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+verification
hw/rvseed_pkg.sv
hw/rvseed_pipe_if.sv
hw/rvseed_fetch.sv
hw/rvseed_decode.sv
hw/rvseed_execute.sv
hw/rvseed_memory.sv
hw/rvseed_writeback.sv
hw/rvseed_top.sv
verification/rvseed_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= rvseed_tb
RTL_TOP   ?= rvseed_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timing
PASS_TEXT ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) verification/rvseed_programs.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
